// ==== sources.f ====
hw/cache_pkg.sv
hw/mem_pkg.sv
hw/cache_fill_ctrl.sv
hw/cache_tag_array.sv
hw/cache_data_array.sv
hw/main_memory.sv
hw/cache_top.sv
testbench/cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --top-module cache_tb -f sources.f -o cache_sim
./obj_dir/cache_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== testbench/cache_tb.sv ====
// Drives held reads into cache_top and checks stall and read data against a reference model.
`timescale 1ns/1ps

module cache_tb;
  import mem_pkg::*;

  localparam int WAIT_LIMIT = 200; // Cycles a single read may take before it counts as hung.
  localparam int NUM_RANDOM = 300; // Reads in the random mix.

  logic        clk;
  logic        rst;
  logic        rd_en;
  logic [15:0] rd_addr;
  logic        proceed;
  logic [15:0] rd_data;
  logic        rd_valid;
  logic        stall;

  logic [5:0]  ref_tag [64][2];   // Model tags per set and way.
  bit          ref_valid [64][2]; // Model valid bits.
  bit          ref_lru_way [64];  // Model way that goes next in each set.
  logic [31:0] lcg_state;         // Random generator state.

  event        result_ready;      // Fires when a finished read is ready to compare.
  logic [15:0] got_addr;          // Address of the finished read.
  logic [15:0] got_data;          // Data seen in its hit cycle.
  bit          got_stall;         // A stall was seen before the hit.
  bit          exp_stall;         // Model says the read misses.
  int          data_errs;
  int          stall_errs;
  int          proto_errs;
  int          timeouts;

  cache_top u_cache_top (
    .clk      (clk),
    .rst      (rst),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .proceed  (proceed),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .stall    (stall)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period.
  end

  ////////////////////
  // Reference model.
  ////////////////////
  // Memory words hold their even byte address XOR the pattern.
  function automatic logic [15:0] expected_word(input logic [15:0] addr);
    return (addr & 16'hFFFE) ^ MEM_PATTERN;
  endfunction

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345; // Classic 32-bit LCG step.
    return lcg_state;
  endfunction

  // Looks the address up, installs it on a miss and updates LRU; returns 1 on a miss.
  function automatic bit predict_access(input logic [15:0] addr);
    logic [5:0] set;
    logic [5:0] tag;
    bit         way;
    bit         miss;
    set  = addr[9:4];
    tag  = addr[15:10];
    miss = 1'b0;
    if (ref_valid[set][0] && ref_tag[set][0] == tag) begin
      way = 1'b0;
    end else if (ref_valid[set][1] && ref_tag[set][1] == tag) begin
      way = 1'b1;
    end else begin
      miss = 1'b1; // Empty way first, else the least recently used one.
      way  = !ref_valid[set][0] ? 1'b0 : (!ref_valid[set][1] ? 1'b1 : ref_lru_way[set]);
      ref_tag[set][way]   = tag;
      ref_valid[set][way] = 1'b1;
    end
    ref_lru_way[set] = ~way; // The other way is now older.
    return miss;
  endfunction

  ////////////////////
  // Stimulus.
  ////////////////////
  // Holds one read until rd_valid, keeping proceed low for the first gap cycles.
  task automatic run_read(input logic [15:0] addr, input int gap);
    int cycles;
    bit stalled;
    cycles  = 0;
    stalled = 1'b0;
    @(negedge clk);
    rd_en     = 1'b1;
    rd_addr   = addr;
    proceed   = (gap == 0);
    exp_stall = predict_access(addr);
    #1;
    while (!rd_valid && cycles < WAIT_LIMIT) begin
      stalled = stalled | stall;
      if (cycles < gap && !stall) begin
        $display("stall dropped while proceed was low, addr %h", addr);
        proto_errs++;
      end
      @(negedge clk);
      cycles++;
      if (cycles >= gap) proceed = 1'b1; // Grant memory once the gap is over.
      #1;
    end
    if (!rd_valid) begin
      $display("read of address %h never returned rd_valid", addr);
      timeouts++;
    end else begin
      if (exp_stall && cycles < gap) begin
        $display("rd_valid rose before proceed was given, addr %h", addr);
        proto_errs++;
      end
      if (stall) begin
        $display("stall is high in the hit cycle, addr %h", addr);
        proto_errs++;
      end
      got_addr  = addr;
      got_data  = rd_data;
      got_stall = stalled;
      -> result_ready;
    end
  endtask

  // Compares each finished read with the model.
  always @(result_ready) begin
    if (got_data !== expected_word(got_addr)) begin
      $display("FAILED rd_data addr=%h got=%h exp=%h", got_addr, got_data,
               expected_word(got_addr));
      data_errs++;
    end
    if (got_stall != exp_stall) begin
      $display("FAILED stall addr=%h got=%h exp=%h", got_addr, got_stall, exp_stall);
      stall_errs++;
    end
  end

  initial begin
    logic [31:0] r;
    rst     = 1'b1; // Quiet inputs during reset.
    rd_en   = 1'b0;
    rd_addr = '0;
    proceed = 1'b0;
    lcg_state  = 32'd13;
    data_errs  = 0;
    stall_errs = 0;
    proto_errs = 0;
    timeouts   = 0;
    for (int s = 0; s < 64; s++) begin
      ref_valid[s][0] = 1'b0;
      ref_valid[s][1] = 1'b0;
      ref_lru_way[s]  = 1'b0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    if (stall || rd_valid) begin
      $display("stall or rd_valid high after reset with rd_en low");
      proto_errs++;
    end

    run_read(16'h1234, 0); // Cold miss fill.
    for (int i = 0; i < 8; i++) begin
      run_read(16'h1230 + 16'(2 * i), 0); // Whole block hits.
    end

    run_read(16'h0450, 0); // Tags 1, 2 and 3 share set 5.
    run_read(16'h0850, 0);
    run_read(16'h0450, 0); // Both tags are resident.
    run_read(16'h0850, 0);
    run_read(16'h0450, 0); // Tag 1 becomes most recent.
    run_read(16'h0C50, 0); // Evicts tag 2.
    run_read(16'h0450, 0); // Kept tag still hits.
    run_read(16'h0850, 0); // Evicted tag misses again.

    run_read(16'h2A60, 9); // Fill held back by proceed.

    for (int n = 0; n < NUM_RANDOM; n++) begin
      r = next_rand();
      run_read({4'b0, r[17:16], 3'b0, r[20:18], r[23:21], 1'b0}, int'(r[25:24]));
    end

    @(negedge clk);
    rd_en = 1'b0;
    repeat (2) @(posedge clk);
    $display("Errors: data %0d, stall %0d, protocol %0d, timeouts %0d",
             data_errs, stall_errs, proto_errs, timeouts);
    if (data_errs + stall_errs + proto_errs + timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/cache_top.sv ====
// Cache top level: tag store, data store, fill controller and memory model wired together.
`timescale 1ns/1ps

module cache_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         rd_en,    // CPU read request, held while stalled.
  input  logic [cache_pkg::ADDR_W-1:0] rd_addr,  // CPU byte address, held while stalled.
  input  logic                         proceed,  // Arbiter grant for memory.
  output logic [cache_pkg::ADDR_W-1:0] rd_data,  // Read word.
  output logic                         rd_valid, // rd_data is good this cycle.
  output logic                         stall     // Miss in progress.
);
  import cache_pkg::*;

  logic                hit;                  // Tag match.
  logic                hit_way;              // Matching way.
  logic                miss_detected;        // No tag match.
  logic                victim_way;           // Way a fill replaces.
  logic                fsm_busy;             // Fill in progress.
  logic                mem_read;             // Memory read strobe.
  logic [ADDR_W-1:0]   main_memory_address;  // Memory read address.
  logic [ADDR_W-1:0]   memory_data;          // Memory return data.
  logic                memory_data_valid;    // Memory return strobe.
  logic [ADDR_W-1:0]   cache_memory_address; // Fill word address.
  logic [ADDR_W-1:0]   fill_data;            // Fill word.
  logic                write_data_array;     // Fill word write.
  logic                write_tag_array;      // Tag entry write.
  logic [ENTRY_W-1:0]  tag_out;              // New tag entry.

  assign stall    = fsm_busy;
  assign rd_valid = hit; // Zero-latency hit.

  cache_tag_array u_cache_tag_array (
    .clk             (clk),
    .rst             (rst),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .write_tag_array (write_tag_array),
    .tag_out         (tag_out),
    .hit             (hit),
    .hit_way         (hit_way),
    .miss_detected   (miss_detected),
    .victim_way      (victim_way)
  );

  cache_data_array u_cache_data_array (
    .clk                  (clk),
    .rd_addr              (rd_addr),
    .hit_way              (hit_way),
    .write_data_array     (write_data_array),
    .cache_memory_address (cache_memory_address),
    .victim_way           (victim_way),
    .fill_data            (fill_data),
    .rd_data              (rd_data)
  );

  cache_fill_ctrl u_cache_fill_ctrl (
    .clk                  (clk),
    .rst                  (rst),
    .proceed              (proceed),
    .miss_detected        (miss_detected),
    .miss_address         (rd_addr),
    .memory_data          (memory_data),
    .memory_data_valid    (memory_data_valid),
    .fsm_busy             (fsm_busy),
    .mem_read             (mem_read),
    .main_memory_address  (main_memory_address),
    .cache_memory_address (cache_memory_address),
    .fill_data            (fill_data),
    .write_data_array     (write_data_array),
    .write_tag_array      (write_tag_array),
    .tag_out              (tag_out)
  );

  main_memory u_main_memory (
    .clk                 (clk),
    .rst                 (rst),
    .mem_read            (mem_read),
    .main_memory_address (main_memory_address),
    .memory_data         (memory_data),
    .memory_data_valid   (memory_data_valid)
  );

endmodule

// ==== hw/main_memory.sv ====
// Behavioral main memory: returns each read strobe after a fixed, pipelined latency.
`timescale 1ns/1ps

module main_memory (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         mem_read,            // Read strobe.
  input  logic [cache_pkg::ADDR_W-1:0] main_memory_address, // Byte address of the read.
  output logic [cache_pkg::ADDR_W-1:0] memory_data,         // Returned word.
  output logic                         memory_data_valid    // Strobe for memory_data.
);
  import cache_pkg::*;
  import mem_pkg::*;

  logic [ADDR_W-1:0]      mem [MEM_WORDS];        // Word array.
  logic [MEM_LATENCY-1:0] valid_pipe;             // Read strobes in flight.
  logic [ADDR_W-1:0]      data_pipe [MEM_LATENCY]; // Read data in flight.

  // Every word holds its byte address XOR the pattern.
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = ADDR_W'(i * WORD_BYTES) ^ MEM_PATTERN;
    end
  end

  ////////////////////
  // Return pipeline.
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_pipe <= '0; // Nothing in flight after reset.
    end else begin
      valid_pipe <= {valid_pipe[MEM_LATENCY-2:0], mem_read}; // In order, one per cycle.
    end
  end

  always_ff @(posedge clk) begin
    data_pipe[0] <= mem[main_memory_address[ADDR_W-1 -: MEM_ADDR_W]]; // Byte bit dropped.
    for (int i = 1; i < MEM_LATENCY; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  assign memory_data       = data_pipe[MEM_LATENCY-1];
  assign memory_data_valid = valid_pipe[MEM_LATENCY-1]; // Exactly MEM_LATENCY after the strobe.

endmodule

// ==== hw/cache_data_array.sv ====
// Two-way word store: combinational read for hits and one write port for block fills.
`timescale 1ns/1ps

module cache_data_array (
  input  logic                         clk,
  input  logic [cache_pkg::ADDR_W-1:0] rd_addr,              // CPU byte address.
  input  logic                         hit_way,              // Way to read from.
  input  logic                         write_data_array,     // Fill word write enable.
  input  logic [cache_pkg::ADDR_W-1:0] cache_memory_address, // Byte address of the fill word.
  input  logic                         victim_way,           // Way being filled.
  input  logic [cache_pkg::ADDR_W-1:0] fill_data,            // Fill word.
  output logic [cache_pkg::ADDR_W-1:0] rd_data               // Word for the CPU.
);
  import cache_pkg::*;

  logic [ADDR_W-1:0] words [NUM_WAYS*NUM_SETS*WORDS_PER_BLOCK]; // Flat {way, set, offset}.
  logic [WAY_W+SET_W+OFF_W-1:0] rd_idx; // Read location.
  logic [WAY_W+SET_W+OFF_W-1:0] wr_idx; // Fill location.

  ////////////////////
  // Read port.
  ////////////////////
  assign rd_idx  = {hit_way, rd_addr[SET_LSB +: SET_W], rd_addr[OFF_LSB +: OFF_W]};
  assign rd_data = words[rd_idx]; // Same-cycle data, qualified outside by hit.

  ////////////////////
  // Fill port.
  ////////////////////
  // The victim stays fixed during a fill because the CPU holds its address.
  assign wr_idx = {victim_way,
                   cache_memory_address[SET_LSB +: SET_W],
                   cache_memory_address[OFF_LSB +: OFF_W]};

  always_ff @(posedge clk) begin
    if (write_data_array) begin
      words[wr_idx] <= fill_data; // One word per returned memory strobe.
    end
  end

endmodule

// ==== hw/cache_tag_array.sv ====
// Two-way tag store: compares both ways, picks the victim and keeps the LRU bits up to date.
`timescale 1ns/1ps

module cache_tag_array (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          rd_en,           // CPU read request.
  input  logic [cache_pkg::ADDR_W-1:0]  rd_addr,         // CPU byte address.
  input  logic                          write_tag_array, // Install tag_out at the end of a fill.
  input  logic [cache_pkg::ENTRY_W-1:0] tag_out,         // Entry from the fill controller.
  output logic                          hit,             // Request matches a valid way.
  output logic                          hit_way,         // Way that matched.
  output logic                          miss_detected,   // Request matches neither way.
  output logic                          victim_way       // Way a fill replaces.
);
  import cache_pkg::*;

  logic [ENTRY_W-1:0]  tags [NUM_SETS][NUM_WAYS]; // Entry per set and way.
  logic [SET_W-1:0]    set_idx;                   // Set of the request.
  logic [TAG_W-1:0]    addr_tag;                  // Tag of the request.
  logic [ENTRY_W-1:0]  entry0;                    // Way 0 entry of the set.
  logic [ENTRY_W-1:0]  entry1;                    // Way 1 entry of the set.
  logic [NUM_WAYS-1:0] match;                     // Per-way valid tag match.

  assign set_idx  = rd_addr[SET_LSB +: SET_W];
  assign addr_tag = rd_addr[TAG_LSB +: TAG_W];
  assign entry0   = tags[set_idx][0];
  assign entry1   = tags[set_idx][1];

  ////////////////////
  // Lookup.
  ////////////////////
  assign match[0] = entry0[VALID_BIT] && (entry0[ENTRY_W-1 -: TAG_W] == addr_tag);
  assign match[1] = entry1[VALID_BIT] && (entry1[ENTRY_W-1 -: TAG_W] == addr_tag);

  assign hit           = rd_en && (|match);
  assign hit_way       = match[1];          // Only one way can hold a given tag.
  assign miss_detected = rd_en && !(|match);

  // An empty way is filled first. Otherwise the way marked LRU goes.
  always_comb begin
    if (!entry0[VALID_BIT]) begin
      victim_way = 1'b0;
    end else if (!entry1[VALID_BIT]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = entry0[LRU_BIT] ? 1'b0 : 1'b1;
    end
  end

  ////////////////////
  // Update.
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          tags[s][w] <= '0; // Every way starts invalid.
        end
      end
    end else if (write_tag_array) begin
      tags[set_idx][victim_way]           <= tag_out; // New block, marked most recent.
      tags[set_idx][~victim_way][LRU_BIT] <= 1'b1;    // The other way is now older.
    end else if (hit) begin
      tags[set_idx][hit_way][LRU_BIT]  <= 1'b0; // Just used.
      tags[set_idx][~hit_way][LRU_BIT] <= 1'b1; // Next to be replaced.
    end
  end

endmodule

// ==== hw/cache_fill_ctrl.sv ====
// Block fill FSM: on a miss it waits for proceed, reads eight words and streams them into the cache.
`timescale 1ns/1ps

module cache_fill_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          proceed,              // Memory is ours to use.
  input  logic                          miss_detected,        // Held request misses both ways.
  input  logic [cache_pkg::ADDR_W-1:0]  miss_address,         // Address of the held request.
  input  logic [cache_pkg::ADDR_W-1:0]  memory_data,          // Word returned by memory.
  input  logic                          memory_data_valid,    // Strobe for memory_data.
  output logic                          fsm_busy,             // Stall for the CPU.
  output logic                          mem_read,             // One strobe per word read.
  output logic [cache_pkg::ADDR_W-1:0]  main_memory_address,  // Byte address of the read.
  output logic [cache_pkg::ADDR_W-1:0]  cache_memory_address, // Byte address of the fill word.
  output logic [cache_pkg::ADDR_W-1:0]  fill_data,            // Word to write into the cache.
  output logic                          write_data_array,     // Fill word write enable.
  output logic                          write_tag_array,      // New tag entry write enable.
  output logic [cache_pkg::ENTRY_W-1:0] tag_out               // New tag entry.
);
  import cache_pkg::*;
  import mem_pkg::*;

  typedef enum logic {IDLE, WAIT} state_t;

  state_t            state;                    // Current FSM state.
  state_t            nxt_state;                // Next FSM state.
  logic [OFF_W:0]    issue_cnt;                // Reads sent so far, stops at eight.
  logic [OFF_W-1:0]  word_cnt;                 // Words written so far.
  logic              start_fill;               // Miss seen in IDLE, load the block base.
  logic              last_word;                // The eighth word is arriving.
  logic [ADDR_W-1:0] addr_dly [MEM_LATENCY];   // Read addresses on their way back.

  assign start_fill = (state == IDLE) && miss_detected; // Reloads every cycle proceed is low.
  assign mem_read   = (state == WAIT) && !issue_cnt[OFF_W]; // Counter MSB set means eight sent.

  assign write_data_array = (state == WAIT) && memory_data_valid; // Each word written on arrival.
  assign last_word        = write_data_array && (word_cnt == '1);  // Offset counter about to wrap.
  assign write_tag_array  = last_word; // Tag goes in together with the last word.

  assign fill_data = memory_data; // Data passes straight from memory into the data store.
  assign tag_out   = {miss_address[TAG_LSB +: TAG_W], 1'b1, 1'b0}; // Valid, most recently used.

  ////////////////////
  // State register.
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE; // No fill in progress after reset.
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    nxt_state = state;    // Hold by default.
    fsm_busy  = 1'b0;     // No stall unless a miss is open.
    case (state)
      IDLE: begin
        fsm_busy = miss_detected; // Stall at once, even while waiting for proceed.
        if (miss_detected && proceed) begin
          nxt_state = WAIT; // Memory granted, start reading.
        end
      end
      WAIT: begin
        fsm_busy = 1'b1; // Busy until the tag entry is written.
        if (last_word) begin
          nxt_state = IDLE; // Held request hits on the next cycle.
        end
      end
    endcase
  end

  ////////////////////
  // Counters.
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      issue_cnt <= '0;
      word_cnt  <= '0;
    end else if (start_fill) begin
      issue_cnt <= '0; // Fresh count for each block.
      word_cnt  <= '0;
    end else begin
      if (mem_read) begin
        issue_cnt <= issue_cnt + 1'b1; // One more read in flight.
      end
      if (write_data_array) begin
        word_cnt <= word_cnt + 1'b1; // One more word stored.
      end
    end
  end

  ////////////////////
  // Read address and its delay line.
  ////////////////////
  always_ff @(posedge clk) begin
    if (start_fill) begin
      main_memory_address <= miss_address & ~ADDR_W'(BLOCK_BYTES - 1); // First word of block.
    end else if (mem_read) begin
      main_memory_address <= main_memory_address + ADDR_W'(WORD_BYTES); // Next word.
    end
  end

  // Delay matches memory latency, so the last stage lines up with each returned word.
  always_ff @(posedge clk) begin
    addr_dly[0] <= main_memory_address;
    for (int i = 1; i < MEM_LATENCY; i++) begin
      addr_dly[i] <= addr_dly[i-1];
    end
  end

  assign cache_memory_address = addr_dly[MEM_LATENCY-1]; // Address of the word now on the bus.

endmodule

// ==== hw/mem_pkg.sv ====
// Main-memory model constants, shared by the memory model and the fill controller.
package mem_pkg;

  ////////////////////
  // Timing and size.
  ////////////////////
  localparam int MEM_LATENCY = 4;     // Cycles from a read strobe to its valid data.
  localparam int MEM_WORDS   = 32768; // 64 KB of byte address space in 16-bit words.
  localparam int MEM_ADDR_W  = 15;    // Word index width into the memory array.

  ////////////////////
  // Content pattern.
  ////////////////////
  // Every word holds its own byte address XOR this constant, so any
  // word read back can be checked without a copy of the memory.
  localparam logic [15:0] MEM_PATTERN = 16'h5A3C;

endpackage

// ==== hw/cache_pkg.sv ====
// Cache geometry, address field positions and tag-entry layout, imported by every cache block.
package cache_pkg;

  ////////////////////
  // Address and geometry.
  ////////////////////
  localparam int ADDR_W          = 16; // Byte address width, also the data word width.
  localparam int TAG_W           = 6;  // Tag is address bits 15 down to 10.
  localparam int SET_W           = 6;  // Set index is address bits 9 down to 4.
  localparam int OFF_W           = 3;  // Word offset is address bits 3 down to 1.
  localparam int NUM_SETS        = 64; // One set per index value.
  localparam int WORDS_PER_BLOCK = 8;  // Eight 16-bit words make one 16-byte block.
  localparam int NUM_WAYS        = 2;  // Two-way set associative.
  localparam int WAY_W           = $clog2(NUM_WAYS); // Width of a way number.

  localparam int TAG_LSB = 10; // Lowest tag bit in the address.
  localparam int SET_LSB = 4;  // Lowest set index bit in the address.
  localparam int OFF_LSB = 1;  // Lowest word offset bit; bit 0 selects the byte.

  localparam int BLOCK_BYTES = 16; // Block alignment step in bytes.
  localparam int WORD_BYTES  = 2;  // Address step between words of a fill.

  ////////////////////
  // Tag entry layout.
  ////////////////////
  // The entry is {tag, valid, lru}.
  localparam int ENTRY_W   = 8; // Tag plus valid plus LRU.
  localparam int VALID_BIT = 1; // Set once the way holds a filled block.
  localparam int LRU_BIT   = 0; // Set on the way that is next to be replaced.

endpackage
